// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = tb_core
FILELIST = sim.f
PASS_MSG = *** TEST PASSED ***

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

obj_dir/V$(TOP): $(FILELIST)
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F '$(PASS_MSG)' > /dev/null

clean:
	rm -rf obj_dir

// File: sim.f
+incdir+verilog
verilog/core_pkg.sv
verilog/fetch_unit.sv
verilog/decode_unit.sv
verilog/execute_unit.sv
verilog/reg_file.sv
verilog/data_access.sv
verilog/core_top.sv
verif/tb_checker.sv
verif/tb_core.sv

// File: verif/tb_checker.sv
`default_nettype none
`include "core_macros.svh"

module tb_checker #(
    parameter int NROWS = 1
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  commit_valid,
    input  logic [`CORE_XLEN-1:0] commit_pc,
    input  logic [31:0]           commit_instr,
    input  logic                  commit_we,
    input  logic [4:0]            commit_rd,
    input  logic [`CORE_XLEN-1:0] commit_data,
    input  logic [95:0]           exp_name,
    input  logic [`CORE_XLEN-1:0] exp_pc,
    input  logic [31:0]           exp_instr,
    input  logic                  exp_we,
    input  logic [4:0]            exp_rd,
    input  logic [`CORE_XLEN-1:0] exp_data,
    output int                    row_idx,
    output logic                  done,
    output int                    fail_count
);

    timeunit 1ns;
    timeprecision 100ps;

    int pass_count;

    initial begin
        row_idx    = 0;
        done       = 1'b0;
        fail_count = 0;
        pass_count = 0;
    end

    // Commit ports settle well before the falling edge
    always @(negedge clk) begin
        logic  ok;
        string exp_s;
        string act_s;
        ok = 1'b1;
        if (arst_n && commit_valid && !done) begin
            if (commit_pc !== exp_pc || commit_we !== exp_we ||
                commit_instr !== exp_instr) begin
                ok = 1'b0;
            end
            if (exp_we && (commit_rd !== exp_rd || commit_data !== exp_data)) begin
                ok = 1'b0; // Rows without a write only check pc, instr and we
            end
            exp_s = $sformatf("pc=%h we=%b rd=%0d data=%h instr=%h",
                              exp_pc, exp_we, exp_rd, exp_data, exp_instr);
            act_s = $sformatf("pc=%h we=%b rd=%0d data=%h instr=%h",
                              commit_pc, commit_we, commit_rd, commit_data, commit_instr);
            if (ok) begin
                pass_count++;
                $display("PASS %0s %0s", exp_name, act_s);
            end else begin
                fail_count++;
                $display("FAIL %0s expected %0s actual %0s", exp_name, exp_s, act_s);
            end
            row_idx++;
            if (row_idx == NROWS) begin
                done = 1'b1;
                $display("Checked %0d rows: %0d passed, %0d failed",
                         NROWS, pass_count, fail_count);
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/tb_core.sv
`default_nettype none
`include "core_macros.svh"

module tb_core;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NROWS = 29;

    logic                  clk;
    logic                  arst_n;
    logic                  ibus_valid;
    logic [`CORE_XLEN-1:0] ibus_addr;
    logic                  ibus_data_ok;
    logic [31:0]           ibus_data;
    logic                  dbus_valid;
    logic [`CORE_XLEN-1:0] dbus_addr;
    logic                  dbus_write;
    logic [`CORE_XLEN-1:0] dbus_wdata;
    logic                  dbus_data_ok;
    logic [`CORE_XLEN-1:0] dbus_rdata;
    logic                  commit_valid;
    logic [`CORE_XLEN-1:0] commit_pc;
    logic [31:0]           commit_instr;
    logic                  commit_we;
    logic [4:0]            commit_rd;
    logic [`CORE_XLEN-1:0] commit_data;

    logic [31:0]           imem [64];
    logic [`CORE_XLEN-1:0] dmem [64];
    int                    seed;

    logic [95:0]           row_name [NROWS];
    logic [`CORE_XLEN-1:0] row_pc   [NROWS];
    logic [31:0]           row_word [NROWS];
    logic                  row_we   [NROWS];
    logic [4:0]            row_rd   [NROWS];
    logic [`CORE_XLEN-1:0] row_data [NROWS];

    logic [95:0]           exp_name;
    logic [`CORE_XLEN-1:0] exp_pc;
    logic [31:0]           exp_instr;
    logic                  exp_we;
    logic [4:0]            exp_rd;
    logic [`CORE_XLEN-1:0] exp_data;
    int                    row_idx;
    logic                  done;
    int                    fail_count;

    core_top i_dut (
        .clk, .arst_n, .ibus_valid, .ibus_addr, .ibus_data_ok, .ibus_data, .dbus_valid,
        .dbus_addr, .dbus_write, .dbus_wdata, .dbus_data_ok, .dbus_rdata, .commit_valid,
        .commit_pc, .commit_instr, .commit_we, .commit_rd, .commit_data
    );

    tb_checker #(.NROWS(NROWS)) i_checker (
        .clk, .arst_n, .commit_valid, .commit_pc, .commit_instr, .commit_we, .commit_rd,
        .commit_data, .exp_name, .exp_pc, .exp_instr, .exp_we, .exp_rd, .exp_data,
        .row_idx, .done, .fail_count
    );

    always_comb begin
        if (row_idx < NROWS) begin
            exp_name  = row_name[row_idx];
            exp_pc    = row_pc[row_idx];
            exp_instr = row_word[row_idx];
            exp_we    = row_we[row_idx];
            exp_rd    = row_rd[row_idx];
            exp_data  = row_data[row_idx];
        end else begin
            exp_name  = '0;
            exp_pc    = '0;
            exp_instr = '0;
            exp_we    = 1'b0;
            exp_rd    = '0;
            exp_data  = '0;
        end
    end

    always #20 clk = ~clk;

    task automatic add_row(input int idx, input logic [95:0] name, input logic [63:0] pc,
                           input logic [31:0] word, input logic we, input logic [4:0] rd,
                           input logic [63:0] data);
        row_name[idx] = name;
        row_pc[idx]   = pc;
        row_word[idx] = word;
        row_we[idx]   = we;
        row_rd[idx]   = rd;
        row_data[idx] = data;
    endtask

    task automatic fill_table();
        add_row(0,  "addi_pos", 64'h00, 32'h00500093, 1'b1, 5'd1,  64'd5);
        add_row(1,  "addi_neg", 64'h04, 32'hffd00113, 1'b1, 5'd2,  64'hffff_ffff_ffff_fffd);
        add_row(2,  "sub_neg",  64'h08, 32'h402081b3, 1'b1, 5'd3,  64'd8);
        add_row(3,  "slt_neg",  64'h0c, 32'h00112233, 1'b1, 5'd4,  64'd1);
        add_row(4,  "lui",      64'h10, 32'h123452b7, 1'b1, 5'd5,  64'h1234_5000);
        add_row(5,  "auipc",    64'h14, 32'h00001317, 1'b1, 5'd6,  64'h1014);
        add_row(6,  "xori",     64'h18, 32'h0ff2c393, 1'b1, 5'd7,  64'h1234_50ff);
        add_row(7,  "andi",     64'h1c, 32'h0f03f413, 1'b1, 5'd8,  64'hf0);
        add_row(8,  "ori",      64'h20, 32'h70046493, 1'b1, 5'd9,  64'h7f0);
        add_row(9,  "slli",     64'h24, 32'h02809513, 1'b1, 5'd10, 64'h0000_0500_0000_0000);
        add_row(10, "srli",     64'h28, 32'h03c15593, 1'b1, 5'd11, 64'hf);
        add_row(11, "add",      64'h2c, 32'h00b50633, 1'b1, 5'd12, 64'h0000_0500_0000_000f);
        add_row(12, "wr_x0",    64'h30, 32'h00708013, 1'b1, 5'd0,  64'd12);
        add_row(13, "rd_x0",    64'h34, 32'h001066b3, 1'b1, 5'd13, 64'd5);
        add_row(14, "sd",       64'h38, 32'h00c03823, 1'b0, 5'd0,  64'd0);
        add_row(15, "ld",       64'h3c, 32'h01003703, 1'b1, 5'd14, 64'h0000_0500_0000_000f);
        add_row(16, "xor_ld",   64'h40, 32'h00c747b3, 1'b1, 5'd15, 64'd0);
        add_row(17, "beq_t",    64'h44, 32'h00d08463, 1'b0, 5'd0,  64'd0);
        add_row(18, "bne_nt",   64'h4c, 32'h00d09463, 1'b0, 5'd0,  64'd0);
        add_row(19, "blt_t",    64'h50, 32'h00114463, 1'b0, 5'd0,  64'd0);
        add_row(20, "bge_nt",   64'h58, 32'h00115463, 1'b0, 5'd0,  64'd0);
        add_row(21, "blt_nt",   64'h5c, 32'h0020c463, 1'b0, 5'd0,  64'd0);
        add_row(22, "bne_t",    64'h60, 32'h00209463, 1'b0, 5'd0,  64'd0);
        add_row(23, "bge_t",    64'h68, 32'h0020d463, 1'b0, 5'd0,  64'd0);
        add_row(24, "beq_nt",   64'h70, 32'h00208463, 1'b0, 5'd0,  64'd0);
        add_row(25, "jal",      64'h74, 32'h00c008ef, 1'b1, 5'd17, 64'h78);
        add_row(26, "addi_tgt", 64'h80, 32'h09100913, 1'b1, 5'd18, 64'h91);
        add_row(27, "jalr",     64'h84, 32'h000909e7, 1'b1, 5'd19, 64'h88);
        add_row(28, "add_link", 64'h90, 32'h01388a33, 1'b1, 5'd20, 64'h100);
    endtask

    task automatic load_memories();
        for (int i = 0; i < 64; i++) begin
            imem[i] = {12'(i), 20'h00813}; // Skipped slots hold addi x16,x0,index
            dmem[i] = {32'hdada_0000, 32'(i)};
        end
        for (int r = 0; r < NROWS; r++) begin
            imem[row_pc[r][7:2]] = row_word[r];
        end
    endtask

    // Instruction memory answers after 0 to 3 cycles
    initial begin
        int lat;
        forever begin
            @(posedge clk);
            #2;
            if (arst_n && ibus_valid) begin
                lat = {$random(seed)} % 4;
                repeat (lat) @(posedge clk);
                #2;
                ibus_data    = imem[ibus_addr[7:2]];
                ibus_data_ok = 1'b1;
                @(posedge clk);
                #2;
                ibus_data_ok = 1'b0;
            end
        end
    end

    initial begin
        int lat;
        forever begin
            @(posedge clk);
            #2;
            if (arst_n && dbus_valid) begin
                lat = {$random(seed)} % 4;
                repeat (lat) @(posedge clk);
                #2;
                if (dbus_write) begin
                    dmem[dbus_addr[8:3]] = dbus_wdata;
                end else begin
                    dbus_rdata = dmem[dbus_addr[8:3]];
                end
                dbus_data_ok = 1'b1;
                @(posedge clk);
                #2;
                dbus_data_ok = 1'b0;
            end
        end
    end

    initial begin
        seed         = 83398;
        clk          = 1'b0;
        arst_n       = 1'b0;
        ibus_data_ok = 1'b0;
        ibus_data    = '0;
        dbus_data_ok = 1'b0;
        dbus_rdata   = '0;
        fill_table();
        load_memories();
        repeat (4) @(posedge clk);
        #2;
        arst_n = 1'b1;
        wait (done);
        if (fail_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Twelve cycles per row covers the slowest bus latency with margin
    initial begin
        repeat (NROWS * 12 + 4) @(posedge clk);
        $display("Timeout: only %0d of %0d instructions committed", row_idx, NROWS);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Data path and address width
`define CORE_XLEN 64

// General register count, x0 included
`define CORE_NREGS 32

// Address of the first fetch after reset
`define CORE_RESET_PC 64'h0

`endif

// File: verilog/core_pkg.sv
`default_nettype none

package core_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // One instruction word, read in whichever format the opcode asks for
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_u;

    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SLT, ALU_PASS_B
    } alu_op_e;

    typedef enum logic {ALUB_RS2, ALUB_IMM} alub_sel_e;

    typedef enum logic [1:0] {RD_ALU, RD_PC4, RD_LOAD} rd_sel_e;

    typedef enum logic [1:0] {PC_PLUS4, PC_BRANCH, PC_JALR} pc_sel_e;

endpackage

`default_nettype wire

// File: verilog/core_top.sv
`default_nettype none
`include "core_macros.svh"

module core_top (
    input  logic                  clk,
    input  logic                  arst_n,
    output logic                  ibus_valid,
    output logic [`CORE_XLEN-1:0] ibus_addr,
    input  logic                  ibus_data_ok,
    input  logic [31:0]           ibus_data,
    output logic                  dbus_valid,
    output logic [`CORE_XLEN-1:0] dbus_addr,
    output logic                  dbus_write,
    output logic [`CORE_XLEN-1:0] dbus_wdata,
    input  logic                  dbus_data_ok,
    input  logic [`CORE_XLEN-1:0] dbus_rdata,
    output logic                  commit_valid,
    output logic [`CORE_XLEN-1:0] commit_pc,
    output logic [31:0]           commit_instr,
    output logic                  commit_we,
    output logic [4:0]            commit_rd,
    output logic [`CORE_XLEN-1:0] commit_data
);

    import core_pkg::*;

    localparam logic [2:0] S_START  = 3'd0;
    localparam logic [2:0] S_FETCH  = 3'd1;
    localparam logic [2:0] S_EXEC   = 3'd2;
    localparam logic [2:0] S_MEM    = 3'd3;
    localparam logic [2:0] S_COMMIT = 3'd4;

    logic [2:0]            state;
    logic                  fetch_start, fetch_done, mem_start, mem_done;
    logic [`CORE_XLEN-1:0] pc, pc_plus4, next_pc, wb_data, imm, load_data;
    logic [`CORE_XLEN-1:0] rs1_data, rs2_data, alu_out, br_target;
    logic [`CORE_XLEN-1:0] alu_q, target_q;
    logic                  br_taken, taken_q, mem_op;
    instr_u                instr;
    logic [4:0]            rs1, rs2, rd;
    alu_op_e               alu_op;
    alub_sel_e             alub_sel;
    pc_sel_e               pc_sel;
    rd_sel_e               rd_sel;
    logic                  alua_pc, branch, reg_we, mem_read, mem_write;
    logic [2:0]            branch_funct;

    assign mem_op      = mem_read || mem_write;
    assign fetch_start = (state == S_START) || (state == S_COMMIT); // Next fetch overlaps commit
    assign mem_start   = (state == S_EXEC) && mem_op;
    assign pc_plus4    = pc + `CORE_XLEN'd4;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= S_START;
        end else begin
            case (state)
                S_START:  state <= S_FETCH;
                S_FETCH:  state <= fetch_done ? S_EXEC : S_FETCH;
                S_EXEC:   state <= mem_op ? S_MEM : S_COMMIT;
                S_MEM:    state <= mem_done ? S_COMMIT : S_MEM;
                default:  state <= S_FETCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_EXEC) begin
            alu_q    <= alu_out;
            target_q <= br_target;
            taken_q  <= br_taken;
        end
    end

    always_comb begin
        case (pc_sel)
            PC_BRANCH: next_pc = (taken_q || !branch) ? target_q : pc_plus4; // jal always jumps
            PC_JALR:   next_pc = {alu_q[`CORE_XLEN-1:1], 1'b0};
            default:   next_pc = pc_plus4;
        endcase
    end

    always_comb begin
        case (rd_sel)
            RD_PC4:  wb_data = pc_plus4;
            RD_LOAD: wb_data = load_data;
            default: wb_data = alu_q;
        endcase
    end

    fetch_unit i_fetch (
        .clk, .arst_n, .fetch_start, .next_pc, .pc_load(state == S_COMMIT),
        .ibus_data_ok, .ibus_data, .pc, .instr, .fetch_done, .ibus_valid, .ibus_addr
    );

    decode_unit i_decode (
        .instr, .rs1, .rs2, .rd, .imm, .alu_op, .alub_sel, .alua_pc, .branch,
        .branch_funct, .pc_sel, .rd_sel, .reg_we, .mem_read, .mem_write
    );

    execute_unit i_execute (
        .alu_op, .alub_sel, .alua_pc, .branch, .branch_funct, .pc, .rs1_data, .rs2_data,
        .imm, .alu_out, .br_target, .br_taken
    );

    reg_file i_regs (
        .clk, .arst_n, .rs1, .rs2, .rd, .we(commit_valid && reg_we), .wdata(wb_data),
        .rs1_data, .rs2_data
    );

    data_access i_data (
        .clk, .arst_n, .mem_start, .write(mem_write), .addr(alu_out), .wdata(rs2_data),
        .dbus_data_ok, .dbus_rdata, .rdata(load_data), .mem_done, .dbus_valid, .dbus_addr,
        .dbus_write, .dbus_wdata
    );

    assign commit_valid = (state == S_COMMIT);
    assign commit_pc    = pc;
    assign commit_instr = instr;
    assign commit_we    = reg_we;
    assign commit_rd    = rd;
    assign commit_data  = wb_data;

endmodule

`default_nettype wire

// File: verilog/data_access.sv
`default_nettype none
`include "core_macros.svh"

module data_access (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  mem_start,
    input  logic                  write,
    input  logic [`CORE_XLEN-1:0] addr,
    input  logic [`CORE_XLEN-1:0] wdata,
    input  logic                  dbus_data_ok,
    input  logic [`CORE_XLEN-1:0] dbus_rdata,
    output logic [`CORE_XLEN-1:0] rdata,
    output logic                  mem_done,
    output logic                  dbus_valid,
    output logic [`CORE_XLEN-1:0] dbus_addr,
    output logic                  dbus_write,
    output logic [`CORE_XLEN-1:0] dbus_wdata
);

    logic dbus_hit;

    assign dbus_hit = dbus_valid && dbus_data_ok;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dbus_valid <= 1'b0;
            dbus_write <= 1'b0;
            mem_done   <= 1'b0;
        end else begin
            mem_done <= dbus_hit;
            if (mem_start) begin
                dbus_valid <= 1'b1;
                dbus_write <= write;
            end else if (dbus_hit) begin
                dbus_valid <= 1'b0;
                dbus_write <= 1'b0;
            end
        end
    end

    // Request fields are captured once and held until data_ok
    always_ff @(posedge clk) begin
        if (mem_start) begin
            dbus_addr  <= addr;
            dbus_wdata <= wdata;
        end
        if (dbus_hit && !dbus_write) begin
            rdata <= dbus_rdata;
        end
    end

endmodule

`default_nettype wire

// File: verilog/decode_unit.sv
`default_nettype none
`include "core_macros.svh"

module decode_unit (
    input  core_pkg::instr_u      instr,
    output logic [4:0]            rs1,
    output logic [4:0]            rs2,
    output logic [4:0]            rd,
    output logic [`CORE_XLEN-1:0] imm,
    output core_pkg::alu_op_e     alu_op,
    output core_pkg::alub_sel_e   alub_sel,
    output logic                  alua_pc,
    output logic                  branch,
    output logic [2:0]            branch_funct,
    output core_pkg::pc_sel_e     pc_sel,
    output core_pkg::rd_sel_e     rd_sel,
    output logic                  reg_we,
    output logic                  mem_read,
    output logic                  mem_write
);

    import core_pkg::*;

    // Register fields sit in the same bits for every format
    assign rs1          = instr.r.rs1;
    assign rs2          = instr.r.rs2;
    assign rd           = instr.r.rd;
    assign branch_funct = instr.b.funct3;

    always_comb begin
        imm       = '0;
        alu_op    = ALU_ADD;
        alub_sel  = ALUB_RS2;
        alua_pc   = 1'b0;
        branch    = 1'b0;
        pc_sel    = PC_PLUS4;
        rd_sel    = RD_ALU;
        reg_we    = 1'b0;
        mem_read  = 1'b0;
        mem_write = 1'b0;
        case (instr.r.opcode)
            OP_LUI, OP_AUIPC: begin
                imm      = {{(`CORE_XLEN-32){instr.u.imm[19]}}, instr.u.imm, 12'b0};
                alub_sel = ALUB_IMM;
                alu_op   = (instr.u.opcode == OP_LUI) ? ALU_PASS_B : ALU_ADD;
                alua_pc  = (instr.u.opcode == OP_AUIPC);
                reg_we   = 1'b1;
            end
            OP_JAL: begin
                imm      = {{(`CORE_XLEN-21){instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                            instr.j.imm11, instr.j.imm10_1, 1'b0};
                alub_sel = ALUB_IMM;
                alua_pc  = 1'b1;
                pc_sel   = PC_BRANCH;
                rd_sel   = RD_PC4;
                reg_we   = 1'b1;
            end
            OP_JALR: begin
                imm      = {{(`CORE_XLEN-12){instr.i.imm[11]}}, instr.i.imm};
                alub_sel = ALUB_IMM;
                pc_sel   = PC_JALR;
                rd_sel   = RD_PC4;
                reg_we   = 1'b1;
            end
            OP_BRANCH: begin
                imm    = {{(`CORE_XLEN-13){instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                          instr.b.imm10_5, instr.b.imm4_1, 1'b0};
                branch = 1'b1;
                pc_sel = PC_BRANCH;
            end
            OP_LOAD: begin
                imm      = {{(`CORE_XLEN-12){instr.i.imm[11]}}, instr.i.imm};
                alub_sel = ALUB_IMM;
                rd_sel   = RD_LOAD;
                reg_we   = (instr.i.funct3 == 3'b011); // Only ld is supported
                mem_read = (instr.i.funct3 == 3'b011);
            end
            OP_STORE: begin
                imm       = {{(`CORE_XLEN-12){instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
                alub_sel  = ALUB_IMM;
                mem_write = (instr.s.funct3 == 3'b011);
            end
            OP_IMM: begin
                imm      = {{(`CORE_XLEN-12){instr.i.imm[11]}}, instr.i.imm};
                alub_sel = ALUB_IMM;
                reg_we   = 1'b1;
                case (instr.i.funct3)
                    3'b000:  alu_op = ALU_ADD;
                    3'b111:  alu_op = ALU_AND;
                    3'b110:  alu_op = ALU_OR;
                    3'b100:  alu_op = ALU_XOR;
                    3'b001:  alu_op = ALU_SLL;
                    3'b101: begin
                        alu_op = ALU_SRL;
                        reg_we = (instr.i.imm[11:6] == 6'b0); // srai is not supported
                    end
                    default: reg_we = 1'b0;
                endcase
            end
            OP_REG: begin
                reg_we = 1'b1;
                case ({instr.r.funct7, instr.r.funct3})
                    {7'b0000000, 3'b000}: alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: alu_op = ALU_SUB;
                    {7'b0000000, 3'b111}: alu_op = ALU_AND;
                    {7'b0000000, 3'b110}: alu_op = ALU_OR;
                    {7'b0000000, 3'b100}: alu_op = ALU_XOR;
                    {7'b0000000, 3'b001}: alu_op = ALU_SLL;
                    {7'b0000000, 3'b101}: alu_op = ALU_SRL;
                    {7'b0000000, 3'b010}: alu_op = ALU_SLT;
                    default:              reg_we = 1'b0;
                endcase
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/execute_unit.sv
`default_nettype none
`include "core_macros.svh"

module execute_unit (
    input  core_pkg::alu_op_e     alu_op,
    input  core_pkg::alub_sel_e   alub_sel,
    input  logic                  alua_pc,
    input  logic                  branch,
    input  logic [2:0]            branch_funct,
    input  logic [`CORE_XLEN-1:0] pc,
    input  logic [`CORE_XLEN-1:0] rs1_data,
    input  logic [`CORE_XLEN-1:0] rs2_data,
    input  logic [`CORE_XLEN-1:0] imm,
    output logic [`CORE_XLEN-1:0] alu_out,
    output logic [`CORE_XLEN-1:0] br_target,
    output logic                  br_taken
);

    import core_pkg::*;

    logic [`CORE_XLEN-1:0] op_a;
    logic [`CORE_XLEN-1:0] op_b;
    logic [5:0]            shamt;
    logic                  lt;

    assign op_a      = alua_pc ? pc : rs1_data;
    assign op_b      = (alub_sel == ALUB_IMM) ? imm : rs2_data;
    assign shamt     = op_b[5:0];
    assign br_target = pc + imm;
    assign lt        = $signed(rs1_data) < $signed(rs2_data);

    always_comb begin
        case (alu_op)
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_OR:     alu_out = op_a | op_b;
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SLL:    alu_out = op_a << shamt;
            ALU_SRL:    alu_out = op_a >> shamt;
            ALU_SLT:    alu_out = {{(`CORE_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = op_a + op_b;
        endcase
    end

    always_comb begin
        case (branch_funct)
            3'b000:  br_taken = branch && (rs1_data == rs2_data);
            3'b001:  br_taken = branch && (rs1_data != rs2_data);
            3'b100:  br_taken = branch && lt;
            3'b101:  br_taken = branch && !lt;
            default: br_taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/fetch_unit.sv
`default_nettype none
`include "core_macros.svh"

module fetch_unit (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  fetch_start,
    input  logic [`CORE_XLEN-1:0] next_pc,
    input  logic                  pc_load,
    input  logic                  ibus_data_ok,
    input  logic [31:0]           ibus_data,
    output logic [`CORE_XLEN-1:0] pc,
    output core_pkg::instr_u      instr,
    output logic                  fetch_done,
    output logic                  ibus_valid,
    output logic [`CORE_XLEN-1:0] ibus_addr
);

    logic ibus_hit;

    assign ibus_hit  = ibus_valid && ibus_data_ok;
    assign ibus_addr = pc; // PC only moves at commit, so the address holds while waiting

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc         <= `CORE_RESET_PC;
            ibus_valid <= 1'b0;
            fetch_done <= 1'b0;
        end else begin
            if (pc_load) begin
                pc <= next_pc;
            end
            fetch_done <= ibus_hit;
            if (fetch_start) begin
                ibus_valid <= 1'b1;
            end else if (ibus_hit) begin
                ibus_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ibus_hit) begin
            instr <= ibus_data;
        end
    end

endmodule

`default_nettype wire

// File: verilog/reg_file.sv
`default_nettype none
`include "core_macros.svh"

module reg_file (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [4:0]            rs1,
    input  logic [4:0]            rs2,
    input  logic [4:0]            rd,
    input  logic                  we,
    input  logic [`CORE_XLEN-1:0] wdata,
    output logic [`CORE_XLEN-1:0] rs1_data,
    output logic [`CORE_XLEN-1:0] rs2_data
);

    logic [`CORE_XLEN-1:0] regs [`CORE_NREGS];

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `CORE_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin // x0 keeps its reset value of zero
            regs[rd] <= wdata;
        end
    end

endmodule

`default_nettype wire
